// File: hw/rob_cfg_pkg.sv
/*
  Reorder buffer configuration
  Default buffer geometry plus the constants used by recovery
  truncation and by commit lane indexing
*/
package rob_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry defaults
  ////////////////////////////////////////////////////////////

  // Entry count, must stay a power of two
  localparam int DEFAULT_ROB_SIZE     = 16;

  // Micro-ops allocated or retired per cycle
  localparam int DEFAULT_RENAME_WIDTH = 4;

  ////////////////////////////////////////////////////////////
  // Recovery and commit
  ////////////////////////////////////////////////////////////

  // The recovery slot itself is the last surviving entry
  localparam int RECOVER_SURVIVORS    = 1;

  // Slot distance between neighbouring commit lanes
  localparam int COMMIT_LANE_STRIDE   = 1;

endpackage

// File: hw/uop_pkg.sv
/*
  Micro-op format
  Field widths and the packed micro-op carried through the
  reorder buffer from rename to retirement
*/
package uop_pkg;

  // Field widths
  localparam int PC_BITS        = 32;
  localparam int ARCH_REG_BITS  = 5;
  localparam int PHYS_REG_BITS  = 6;
  localparam int OP_CLASS_BITS  = 2;

  ////////////////////////////////////////////////////////////
  // Packed micro-op, 52 bits
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [PC_BITS-1:0]       pc;
    logic [ARCH_REG_BITS-1:0] dest_arch;
    // New mapping and the one it replaces
    logic [PHYS_REG_BITS-1:0] dest_phys;
    logic [PHYS_REG_BITS-1:0] old_phys;
    logic [OP_CLASS_BITS-1:0] op_class;
    // Only carried, retirement does not act on it
    logic                     exception;
  } micro_op_t;

endpackage

// File: hw/rob_table_if.sv
`timescale 1ns/10ps
/*
  Pointer control to entry table link
  Allocation writes, head window reads and the retire mask
*/
interface rob_table_if #(
  parameter int ROB_SIZE     = rob_cfg_pkg::DEFAULT_ROB_SIZE,
  parameter int RENAME_WIDTH = rob_cfg_pkg::DEFAULT_RENAME_WIDTH
);
  import uop_pkg::*;

  localparam int INDEX_BITS = $clog2(ROB_SIZE);

  // Allocation write lanes
  logic      [RENAME_WIDTH-1:0]                 wr_valid;
  logic      [RENAME_WIDTH-1:0][INDEX_BITS-1:0] wr_index;
  micro_op_t [RENAME_WIDTH-1:0]                 wr_uop;

  // Buffer state
  logic      [INDEX_BITS-1:0]                   head;
  logic      [INDEX_BITS:0]                     count;

  // Window at the head and its retirement
  logic      [RENAME_WIDTH-1:0]                 retire_mask;
  micro_op_t [RENAME_WIDTH-1:0]                 head_uop;
  logic      [RENAME_WIDTH-1:0]                 head_done;

  modport ctrl (output wr_valid, wr_index, wr_uop, head, count, input retire_mask);
  modport entry_tbl (input wr_valid, wr_index, wr_uop, head, output head_uop, head_done);
  modport commit (input head_done, count, output retire_mask);

endinterface

// File: hw/rob_pointer_ctrl.sv
`timescale 1ns/10ps
/*
  Reorder buffer pointer control
  Holds head, live count and rename credits, assigns slots to
  allocating lanes and truncates the buffer on recovery
*/
module rob_pointer_ctrl #(
  parameter int  ROB_SIZE     = rob_cfg_pkg::DEFAULT_ROB_SIZE,
  parameter int  RENAME_WIDTH = rob_cfg_pkg::DEFAULT_RENAME_WIDTH,
  localparam int INDEX_BITS   = $clog2(ROB_SIZE)
) (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic [RENAME_WIDTH-1:0]                 alloc_valid,
  input  uop_pkg::micro_op_t [RENAME_WIDTH-1:0]   alloc_uop,
  input  logic                                    recover,
  input  logic [INDEX_BITS-1:0]                   recover_index,
  output logic [RENAME_WIDTH-1:0][INDEX_BITS-1:0] alloc_index,
  output logic [INDEX_BITS:0]                     credits,
  rob_table_if.ctrl                               tbl
);
  import rob_cfg_pkg::*;

  logic [INDEX_BITS-1:0]   head;
  logic [INDEX_BITS:0]     count;

  logic [RENAME_WIDTH-1:0] lane_take;
  logic [INDEX_BITS:0]     retired;
  logic [INDEX_BITS:0]     accepted;
  logic [INDEX_BITS:0]     kept;
  logic [INDEX_BITS-1:0]   head_next;
  logic [INDEX_BITS:0]     count_next;

  ////////////////////////////////////////////////////////////
  // Slot assignment
  ////////////////////////////////////////////////////////////

  // New slots follow the youngest live entry. Lanes past the
  // credit count find no room, and recovery blocks all lanes
  always_comb begin
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      alloc_index[i] = head + count[INDEX_BITS-1:0] + INDEX_BITS'(i);
      lane_take[i]   = alloc_valid[i] && !recover && ((INDEX_BITS+1)'(i) < credits);
    end
  end

  assign tbl.wr_valid = lane_take;
  assign tbl.wr_index = alloc_index;
  assign tbl.wr_uop   = alloc_uop;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    retired  = '0;
    accepted = '0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      retired  = retired + (INDEX_BITS+1)'(tbl.retire_mask[i]);
      accepted = accepted + (INDEX_BITS+1)'(lane_take[i]);
    end
  end

  // Circular distance from head to the last good slot
  assign kept = {1'b0, recover_index - head} + (INDEX_BITS+1)'(RECOVER_SURVIVORS);

  // Retirement moves the head, allocation only grows the count
  assign head_next = head + retired[INDEX_BITS-1:0];

  always_comb begin
    if (recover) begin
      count_next = kept - retired;
    end else begin
      count_next = count - retired + accepted;
    end
  end

  ////////////////////////////////////////////////////////////
  // State registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      head    <= '0;
      count   <= '0;
      credits <= (INDEX_BITS+1)'(ROB_SIZE);
    end else begin
      head    <= head_next;
      count   <= count_next;
      // Free entries as seen by rename next cycle
      credits <= (INDEX_BITS+1)'(ROB_SIZE) - count_next;
    end
  end

  assign tbl.head  = head;
  assign tbl.count = count;

endmodule

// File: hw/rob_entry_table.sv
`timescale 1ns/10ps
/*
  Reorder buffer entry table
  Micro-op storage with per-entry done flags and a read window
  of consecutive entries starting at the head
*/
module rob_entry_table #(
  parameter int  ROB_SIZE     = rob_cfg_pkg::DEFAULT_ROB_SIZE,
  parameter int  RENAME_WIDTH = rob_cfg_pkg::DEFAULT_RENAME_WIDTH,
  localparam int INDEX_BITS   = $clog2(ROB_SIZE)
) (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic [RENAME_WIDTH-1:0]                 complete_valid,
  input  logic [RENAME_WIDTH-1:0][INDEX_BITS-1:0] complete_index,
  rob_table_if.entry_tbl                          tbl
);
  import uop_pkg::*;

  micro_op_t           uop_mem [ROB_SIZE];
  logic [ROB_SIZE-1:0] done;

  // Payload storage, written by allocation lanes only
  always_ff @(posedge clock) begin
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (tbl.wr_valid[i]) begin
        uop_mem[tbl.wr_index[i]] <= tbl.wr_uop[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Done flags
  ////////////////////////////////////////////////////////////

  // A fresh allocation always starts not done
  always_ff @(posedge clock) begin
    if (reset) begin
      done <= '0;
    end else begin
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (complete_valid[i]) begin
          done[complete_index[i]] <= 1'b1;
        end
      end
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (tbl.wr_valid[i]) begin
          done[tbl.wr_index[i]] <= 1'b0;
        end
      end
    end
  end

  // Head window, index arithmetic wraps on its own
  for (genvar i = 0; i < RENAME_WIDTH; i++) begin : g_window
    logic [INDEX_BITS-1:0] slot;
    assign slot             = tbl.head + INDEX_BITS'(i);
    assign tbl.head_uop[i]  = uop_mem[slot];
    assign tbl.head_done[i] = done[slot];
  end

endmodule

// File: hw/rob_commit_select.sv
`timescale 1ns/10ps
/*
  Reorder buffer commit select
  Retire mask from the leading run of done entries at the head
*/
module rob_commit_select #(
  parameter int  ROB_SIZE     = rob_cfg_pkg::DEFAULT_ROB_SIZE,
  parameter int  RENAME_WIDTH = rob_cfg_pkg::DEFAULT_RENAME_WIDTH,
  localparam int INDEX_BITS   = $clog2(ROB_SIZE)
) (
  rob_table_if.commit tbl
);

  logic [RENAME_WIDTH-1:0] live;
  logic [RENAME_WIDTH-1:0] run;

  ////////////////////////////////////////////////////////////
  // Live lanes
  ////////////////////////////////////////////////////////////

  // Lanes past the live count read stale entries
  always_comb begin
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      live[i] = (INDEX_BITS+1)'(i) < tbl.count;
    end
  end

  ////////////////////////////////////////////////////////////
  // In-order run
  ////////////////////////////////////////////////////////////

  // First lane not done ends the run for all younger lanes
  always_comb begin
    run[0] = live[0] && tbl.head_done[0];
    for (int i = 1; i < RENAME_WIDTH; i++) begin
      run[i] = run[i-1] && live[i] && tbl.head_done[i];
    end
  end

  // Retirement always accepts
  assign tbl.retire_mask = run;

endmodule

// File: hw/rob_top.sv
`timescale 1ns/10ps
/*
  Reorder buffer top level
  Credit-based allocation from rename, out-of-order completion
  and in-order commit of up to RENAME_WIDTH micro-ops per cycle
*/
module rob_top #(
  parameter int  ROB_SIZE     = rob_cfg_pkg::DEFAULT_ROB_SIZE,
  parameter int  RENAME_WIDTH = rob_cfg_pkg::DEFAULT_RENAME_WIDTH,
  localparam int INDEX_BITS   = $clog2(ROB_SIZE)
) (
  input  logic                                    clock,
  input  logic                                    reset,
  // Rename side
  input  logic [RENAME_WIDTH-1:0]                 alloc_valid,
  input  uop_pkg::micro_op_t [RENAME_WIDTH-1:0]   alloc_uop,
  output logic [RENAME_WIDTH-1:0][INDEX_BITS-1:0] alloc_index,
  output logic [INDEX_BITS:0]                     credits,
  // Execution side
  input  logic [RENAME_WIDTH-1:0]                 complete_valid,
  input  logic [RENAME_WIDTH-1:0][INDEX_BITS-1:0] complete_index,
  input  logic                                    recover,
  input  logic [INDEX_BITS-1:0]                   recover_index,
  // Retirement
  output logic [RENAME_WIDTH-1:0]                 commit_valid,
  output uop_pkg::micro_op_t [RENAME_WIDTH-1:0]   commit_uop,
  output logic [RENAME_WIDTH-1:0][INDEX_BITS-1:0] commit_index
);
  import rob_cfg_pkg::*;

  rob_table_if #(.ROB_SIZE(ROB_SIZE), .RENAME_WIDTH(RENAME_WIDTH)) tbl ();

  rob_pointer_ctrl #(.ROB_SIZE(ROB_SIZE), .RENAME_WIDTH(RENAME_WIDTH)) u_pointer_ctrl (
    .clock         (clock),
    .reset         (reset),
    .alloc_valid   (alloc_valid),
    .alloc_uop     (alloc_uop),
    .recover       (recover),
    .recover_index (recover_index),
    .alloc_index   (alloc_index),
    .credits       (credits),
    .tbl           (tbl.ctrl)
  );

  rob_entry_table #(.ROB_SIZE(ROB_SIZE), .RENAME_WIDTH(RENAME_WIDTH)) u_entry_table (
    .clock          (clock),
    .reset          (reset),
    .complete_valid (complete_valid),
    .complete_index (complete_index),
    .tbl            (tbl.entry_tbl)
  );

  rob_commit_select #(.ROB_SIZE(ROB_SIZE), .RENAME_WIDTH(RENAME_WIDTH)) u_commit_select (
    .tbl (tbl.commit)
  );

  // Commit lanes mirror the head window
  assign commit_valid = tbl.retire_mask;
  assign commit_uop   = tbl.head_uop;

  for (genvar i = 0; i < RENAME_WIDTH; i++) begin : g_commit_index
    assign commit_index[i] = tbl.head + INDEX_BITS'(i * COMMIT_LANE_STRIDE);
  end

endmodule

// File: bench/rob_tb.sv
`timescale 1ns/10ps
/*
  Reorder buffer testbench
  Directed tests against a queue model of live slots in program
  order, covering allocation, commit, fill, recovery and discards
*/
module rob_tb;
  import uop_pkg::*;

  localparam int ROB_SIZE     = rob_cfg_pkg::DEFAULT_ROB_SIZE;
  localparam int RENAME_WIDTH = rob_cfg_pkg::DEFAULT_RENAME_WIDTH;
  localparam int INDEX_BITS   = $clog2(ROB_SIZE);
  // Summed test lengths plus margin, in clock cycles
  localparam int WATCHDOG_CYCLES = 400 + 100;

  logic clock;
  logic reset;
  logic      [RENAME_WIDTH-1:0]                 alloc_valid;
  micro_op_t [RENAME_WIDTH-1:0]                 alloc_uop;
  logic      [RENAME_WIDTH-1:0][INDEX_BITS-1:0] alloc_index;
  logic      [INDEX_BITS:0]                     credits;
  logic      [RENAME_WIDTH-1:0]                 complete_valid;
  logic      [RENAME_WIDTH-1:0][INDEX_BITS-1:0] complete_index;
  logic                                         recover;
  logic      [INDEX_BITS-1:0]                   recover_index;
  logic      [RENAME_WIDTH-1:0]                 commit_valid;
  micro_op_t [RENAME_WIDTH-1:0]                 commit_uop;
  logic      [RENAME_WIDTH-1:0][INDEX_BITS-1:0] commit_index;

  // Reference model state
  int        live_q[$];
  int        discarded[$];
  micro_op_t mem_m [ROB_SIZE];
  bit        done_m [ROB_SIZE];
  int        head_m;
  int        uop_seq;
  int        seed = 25;
  int        errors;

  rob_top u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    #(WATCHDOG_CYCLES * 100);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic micro_op_t make_uop(input int seq);
    micro_op_t u;
    u.pc        = 32'h0000_1000 + 32'(seq * 4);
    u.dest_arch = ARCH_REG_BITS'(seq);
    u.dest_phys = PHYS_REG_BITS'(seq + 7);
    u.old_phys  = ~PHYS_REG_BITS'(seq);
    u.op_class  = OP_CLASS_BITS'(seq);
    u.exception = seq[3];
    return u;
  endfunction

  task automatic drive_alloc(input logic [RENAME_WIDTH-1:0] mask);
    alloc_valid = mask;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      alloc_uop[i] = make_uop(uop_seq);
      uop_seq++;
    end
  endtask

  // Completes up to lanes pending live entries, picked at random
  task automatic complete_random(input int lanes);
    int pend[$];
    int pick;
    foreach (live_q[i]) begin
      if (!done_m[live_q[i]]) begin
        pend.push_back(live_q[i]);
      end
    end
    for (int l = 0; l < lanes && pend.size() > 0; l++) begin
      pick = $unsigned($random(seed)) % pend.size();
      complete_valid[l] = 1'b1;
      complete_index[l] = INDEX_BITS'(pend[pick]);
      pend.delete(pick);
    end
  endtask

  // Checks one cycle of outputs, then applies the edge to the model
  task automatic cycle();
    int n_live;
    int n_commit;
    int credit_now;
    int kept;
    int slot;
    logic [RENAME_WIDTH-1:0] exp_commit;
    #1;
    n_live     = live_q.size();
    credit_now = ROB_SIZE - n_live;
    n_commit   = 0;
    while (n_commit < RENAME_WIDTH && n_commit < n_live && done_m[live_q[n_commit]]) begin
      n_commit++;
    end
    exp_commit = '0;
    for (int i = 0; i < n_commit; i++) begin
      exp_commit[i] = 1'b1;
      check_value("commit_index", commit_index[i], live_q[i]);
      check_value("commit_uop", commit_uop[i], mem_m[live_q[i]]);
    end
    check_value("commit_valid", commit_valid, exp_commit);
    check_value("credits", credits, credit_now);
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      check_value("alloc_index", alloc_index[i], (head_m + n_live + i) % ROB_SIZE);
    end
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (complete_valid[i]) begin
        done_m[complete_index[i]] = 1'b1;
      end
    end
    if (recover) begin
      kept = ((int'(recover_index) - head_m + ROB_SIZE) % ROB_SIZE) + 1;
      while (live_q.size() > kept) begin
        void'(live_q.pop_back());
      end
    end else begin
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (alloc_valid[i] && i < credit_now) begin
          slot = (head_m + n_live + i) % ROB_SIZE;
          live_q.push_back(slot);
          mem_m[slot]  = alloc_uop[i];
          done_m[slot] = 1'b0;
        end
      end
    end
    for (int i = 0; i < n_commit; i++) begin
      void'(live_q.pop_front());
    end
    head_m = (head_m + n_commit) % ROB_SIZE;
    @(negedge clock);
    alloc_valid    = '0;
    complete_valid = '0;
    recover        = 1'b0;
  endtask

  task automatic drain(input int lanes);
    for (int k = 0; k < 4 * ROB_SIZE && live_q.size() > 0; k++) begin
      complete_random(lanes);
      cycle();
    end
  endtask

  task automatic check_no_discarded();
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      foreach (discarded[j]) begin
        assert (!(commit_valid[i] && commit_index[i] == discarded[j])) else begin
          errors++;
          $display("ERROR %0t: discarded slot %0d committed", $time, discarded[j]);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    check_value("credits after reset", credits, ROB_SIZE);
    check_value("commit_valid after reset", commit_valid, 0);
    cycle();
    cycle();
  endtask

  // Mixed lane counts, then a second batch that wraps past the last slot
  task automatic test_alloc_wrap();
    logic [RENAME_WIDTH-1:0] masks [6] = '{4'b0111, 4'b0001, 4'b1111, 4'b0011, 4'b0000, 4'b0001};
    foreach (masks[i]) begin
      drive_alloc(masks[i]);
      cycle();
    end
    drain(2);
    drive_alloc(4'b1111);
    cycle();
    drive_alloc(4'b0111);
    cycle();
    drain(1);
  endtask

  task automatic test_random_commit();
    repeat (3) begin
      drive_alloc(4'b1111);
      cycle();
    end
    drain(3);
  endtask

  task automatic test_fill();
    for (int k = 0; k < ROB_SIZE && live_q.size() < ROB_SIZE; k++) begin
      drive_alloc(4'b1111);
      cycle();
    end
    check_value("credits when full", credits, 0);
    // No lane fits while full
    drive_alloc(4'b1111);
    cycle();
    drain(2);
    check_value("credits after drain", credits, ROB_SIZE);
  endtask

  task automatic test_recover();
    int rec;
    repeat (3) begin
      drive_alloc(4'b1111);
      cycle();
    end
    complete_valid    = 4'b0111;
    complete_index[0] = INDEX_BITS'(live_q[0]);
    complete_index[1] = INDEX_BITS'(live_q[1]);
    complete_index[2] = INDEX_BITS'(live_q[6]);
    cycle();
    rec = live_q[4];
    discarded = {};
    for (int i = 5; i < live_q.size(); i++) begin
      discarded.push_back(live_q[i]);
    end
    recover       = 1'b1;
    recover_index = INDEX_BITS'(rec);
    drive_alloc(4'b1111);
    cycle();
    // Two head commits in the recovery cycle leave three survivors
    check_value("alloc_index after recovery", alloc_index[0], (rec + 1) % ROB_SIZE);
    check_value("credits after recovery", credits, ROB_SIZE - 3);
  endtask

  task automatic test_late_complete();
    int k;
    k = 0;
    while (k < discarded.size()) begin
      for (int l = 0; l < RENAME_WIDTH && k < discarded.size(); l++) begin
        complete_valid[l] = 1'b1;
        complete_index[l] = INDEX_BITS'(discarded[k]);
        k++;
      end
      cycle();
      check_no_discarded();
    end
    for (int n = 0; n < 4 * ROB_SIZE && live_q.size() > 0; n++) begin
      complete_random(2);
      cycle();
      check_no_discarded();
    end
  endtask

  initial begin
    reset          = 1'b1;
    alloc_valid    = '0;
    alloc_uop      = '0;
    complete_valid = '0;
    complete_index = '0;
    recover        = 1'b0;
    recover_index  = '0;
    errors         = 0;
    head_m         = 0;
    uop_seq        = 0;
    foreach (done_m[i]) begin
      done_m[i] = 1'b0;
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_reset();
    test_alloc_wrap();
    test_random_commit();
    test_fill();
    test_recover();
    test_late_complete();
    $display("Failed checks: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: ria_rob.f
hw/rob_cfg_pkg.sv
hw/uop_pkg.sv
hw/rob_table_if.sv
hw/rob_pointer_ctrl.sv
hw/rob_entry_table.sv
hw/rob_commit_select.sv
hw/rob_top.sv
bench/rob_tb.sv

// File: Bender.yml
package:
  name: ria_rob

sources:
  - files:
      - hw/rob_cfg_pkg.sv
      - hw/uop_pkg.sv
      - hw/rob_table_if.sv
      - hw/rob_pointer_ctrl.sv
      - hw/rob_entry_table.sv
      - hw/rob_commit_select.sv
      - hw/rob_top.sv
  - target: test
    files:
      - bench/rob_tb.sv
